/* hw/core_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction set definitions shared by decode, execute and the testbench
// Import with core_pkg::* where opcodes or instruction views are needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package core_pkg;

  localparam int WORD_WIDTH      = 32;
  localparam int OPCODE_WIDTH    = 7;
  localparam int REG_INDEX_WIDTH = 5;
  localparam int OFFSET_WIDTH    = 15;
  localparam int R_UNUSED_WIDTH  = WORD_WIDTH - OPCODE_WIDTH - 3 * REG_INDEX_WIDTH;

  // Loads and stores sit in their own opcode group
  typedef enum logic [OPCODE_WIDTH-1:0] {
    NOP  = 7'h00,
    ADD  = 7'h01,
    SUB  = 7'h02,
    MUL  = 7'h03,
    ADDI = 7'h04,
    LDW  = 7'h10,
    LDB  = 7'h11,
    STW  = 7'h12
  } opcode_t;

  typedef struct packed {
    opcode_t                     opcode;
    logic [REG_INDEX_WIDTH-1:0]  rd;
    logic [REG_INDEX_WIDTH-1:0]  rs1;
    logic [REG_INDEX_WIDTH-1:0]  rs2;
    logic [R_UNUSED_WIDTH-1:0]   unused;
  } r_fmt_t;

  // Offset doubles as the ADDI immediate, rd is the store data source
  typedef struct packed {
    opcode_t                     opcode;
    logic [REG_INDEX_WIDTH-1:0]  rd;
    logic [REG_INDEX_WIDTH-1:0]  rs1;
    logic [OFFSET_WIDTH-1:0]     offset;
  } m_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    m_fmt_t m_fmt;
  } instr_word_t;

  localparam instr_word_t NOP_INSTRUCTION = '0;

endpackage

/* hw/pipe_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline bundles, write-back and cache request types
// Import with pipe_pkg::* in every stage that moves these bundles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pipe_pkg;

  import core_pkg::*;

  localparam int MUL_LATENCY     = 4;
  localparam int MUL_COUNT_WIDTH = $clog2(MUL_LATENCY);

  localparam logic [1:0] ALU_ADD = 2'b00;
  localparam logic [1:0] ALU_SUB = 2'b01;
  localparam logic [1:0] ALU_MUL = 2'b10;

  typedef struct packed {
    logic       reg_write;
    logic       mem_to_reg;
    logic [1:0] alu_op;
    logic       alu_src;
    logic       is_imm;
    logic       d_cache_access;
    // Set for a store
    logic       d_cache_op;
    logic       is_byte_op;
    logic       is_mul;
  } decode_ctrl_t;

  typedef struct packed {
    instr_word_t                 instruction;
    logic [REG_INDEX_WIDTH-1:0]  destination_register;
    logic [WORD_WIDTH-1:0]       first_input;
    logic [WORD_WIDTH-1:0]       second_input;
    logic [WORD_WIDTH-1:0]       offset;
    decode_ctrl_t                ctrl;
  } de_bundle_t;

  typedef struct packed {
    logic [REG_INDEX_WIDTH-1:0] rd;
    logic [WORD_WIDTH-1:0]      value;
  } wb_result_t;

  typedef struct packed {
    logic [WORD_WIDTH-1:0] addr;
    logic [WORD_WIDTH-1:0] wdata;
    logic                  write;
    logic                  byte_op;
  } dcache_req_t;

  // Empty stage contents, no write-back and no cache access
  localparam de_bundle_t NOP_BUNDLE = '{
    instruction:          NOP_INSTRUCTION,
    destination_register: '0,
    first_input:          '0,
    second_input:         '0,
    offset:               '0,
    ctrl:                 '0
  };

endpackage

/* hw/register_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Architectural registers, two reads and one write with forwarding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module register_file (
  input  logic        d_cache_access,
  input  logic        rst,
  input  logic [4:0]  rs1_index,
  input  logic [4:0]  rs2_index,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        write_enable,
  input  logic [4:0]  write_index,
  input  logic [31:0] write_data
);

  logic [31:0] regs [32];

  always_ff @(posedge d_cache_access)
  begin
    if (rst)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (write_enable && write_index != 5'd0)
    begin
      regs[write_index] <= write_data;
    end
  end

  // A write in flight is visible to the reader in the same cycle
  assign rs1_data = (rs1_index == 5'd0) ? '0 :
                    (write_enable && write_index == rs1_index) ? write_data : regs[rs1_index];
  assign rs2_data = (rs2_index == 5'd0) ? '0 :
                    (write_enable && write_index == rs2_index) ? write_data : regs[rs2_index];

endmodule

/* hw/decode_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decode and register read, feeds the stage register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_unit
  import core_pkg::*;
  import pipe_pkg::*;
(
  input  instr_word_t instruction,
  input  logic        wb_valid,
  input  wb_result_t  wb,
  input  logic        d_cache_access,
  input  logic        rst,
  output de_bundle_t  bundle
);

  decode_ctrl_t                ctrl;
  logic [REG_INDEX_WIDTH-1:0]  rs2_index;
  logic [WORD_WIDTH-1:0]       rs1_data;
  logic [WORD_WIDTH-1:0]       rs2_data;

  register_file register_file_inst (
    .d_cache_access (d_cache_access),
    .rst            (rst),
    .rs1_index      (instruction.r_fmt.rs1),
    .rs2_index      (rs2_index),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .write_enable   (wb_valid),
    .write_index    (wb.rd),
    .write_data     (wb.value)
  );

  always_comb
  begin
    ctrl      = '0;
    rs2_index = instruction.r_fmt.rs2;
    case (instruction.r_fmt.opcode)
      ADD:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_ADD;
      end
      SUB:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_SUB;
      end
      MUL:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_MUL;
        ctrl.is_mul    = 1'b1;
      end
      ADDI:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.is_imm    = 1'b1;
      end
      LDW, LDB:
      begin
        ctrl.reg_write      = 1'b1;
        ctrl.mem_to_reg     = 1'b1;
        ctrl.alu_src        = 1'b1;
        ctrl.d_cache_access = 1'b1;
        ctrl.is_byte_op     = (instruction.m_fmt.opcode == LDB);
      end
      STW:
      begin
        ctrl.alu_src        = 1'b1;
        ctrl.d_cache_access = 1'b1;
        ctrl.d_cache_op     = 1'b1;
        // Store data comes in through the rd field
        rs2_index           = instruction.m_fmt.rd;
      end
      default:
      begin
        ctrl = '0;
      end
    endcase
  end

  assign bundle.instruction          = instruction;
  assign bundle.destination_register = instruction.m_fmt.rd;
  assign bundle.first_input          = rs1_data;
  assign bundle.second_input         = rs2_data;
  assign bundle.offset = {{(WORD_WIDTH-OFFSET_WIDTH){instruction.m_fmt.offset[OFFSET_WIDTH-1]}},
                          instruction.m_fmt.offset};
  assign bundle.ctrl                 = ctrl;

endmodule

/* hw/decode_stage_register.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode to execute pipeline register with hold and NOP insertion
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_stage_register
  import pipe_pkg::*;
(
  input  logic       d_cache_access,
  input  logic       rst,
  input  de_bundle_t bundle_in,
  input  logic       accept,
  input  logic       set_nop,
  input  logic       lock,
  input  logic       ex_busy,
  output de_bundle_t bundle_out
);

  logic hold;

  // Cache access outstanding or multiply still running
  assign hold = lock | ex_busy;

  always_ff @(posedge d_cache_access)
  begin
    if (rst)
    begin
      bundle_out <= NOP_BUNDLE;
    end
    else if (!hold)
    begin
      if (accept && !set_nop)
      begin
        bundle_out <= bundle_in;
      end
      else
      begin
        // Flushed or missing input, so nothing repeats downstream
        bundle_out <= NOP_BUNDLE;
      end
    end
  end

endmodule

/* hw/mul_latency_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply latency down-counter used by the execute stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mul_latency_timer
  import pipe_pkg::*;
(
  input  logic d_cache_access,
  input  logic rst,
  input  logic start,
  output logic busy,
  output logic last
);

  logic [MUL_COUNT_WIDTH-1:0] count;

  always_ff @(posedge d_cache_access)
  begin
    if (rst)
      count <= '0;
    else if (start)
      count <= MUL_COUNT_WIDTH'(MUL_LATENCY - 1);
    else if (count != '0)
      count <= count - 1'b1;
  end

  assign busy = (count != '0);
  assign last = (count == MUL_COUNT_WIDTH'(1));

endmodule

/* hw/execute_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage: ALU, multiplier, load alignment and write-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module execute_unit
  import core_pkg::*;
  import pipe_pkg::*;
(
  input  logic                  d_cache_access,
  input  logic                  rst,
  input  de_bundle_t            bundle,
  input  logic                  load_done,
  input  logic [WORD_WIDTH-1:0] load_data,
  output logic                  ex_busy,
  output logic                  wb_valid,
  output wb_result_t            wb
);

  logic [WORD_WIDTH-1:0] alu_b;
  logic [WORD_WIDTH-1:0] alu_result;
  logic [WORD_WIDTH-1:0] mem_addr;
  logic [WORD_WIDTH-1:0] load_value;
  logic [WORD_WIDTH-1:0] product_q;
  logic                  mul_start;
  logic                  mul_busy;
  logic                  mul_last;
  logic                  alu_class;

  assign alu_b = bundle.ctrl.alu_src ? bundle.offset : bundle.second_input;

  always_comb
  begin
    case (bundle.ctrl.alu_op)
      ALU_SUB: alu_result = bundle.first_input - alu_b;
      default: alu_result = bundle.first_input + alu_b;
    endcase
  end

  // Starts in the first cycle the multiply sits in the stage
  assign mul_start = bundle.ctrl.is_mul & ~mul_busy;

  mul_latency_timer mul_latency_timer_inst (
    .d_cache_access (d_cache_access),
    .rst            (rst),
    .start          (mul_start),
    .busy           (mul_busy),
    .last           (mul_last)
  );

  always_ff @(posedge d_cache_access)
  begin
    if (mul_start)
      product_q <= bundle.first_input * bundle.second_input;
  end

  // Stage may advance during the final multiply cycle
  assign ex_busy = mul_start | (mul_busy & ~mul_last);

  // Little-endian byte lane from the low address bits
  assign mem_addr   = bundle.first_input + bundle.offset;
  assign load_value = bundle.ctrl.is_byte_op ?
                      WORD_WIDTH'(load_data >> {mem_addr[1:0], 3'b000}) & 32'h0000_00ff :
                      load_data;

  assign alu_class = bundle.ctrl.reg_write & ~bundle.ctrl.mem_to_reg & ~bundle.ctrl.is_mul;

  assign wb_valid = alu_class | (bundle.ctrl.is_mul & mul_last) | load_done;
  assign wb.rd    = bundle.destination_register;
  assign wb.value = load_done ? load_value :
                    bundle.ctrl.is_mul ? product_q : alu_result;

endmodule

/* hw/dcache_access_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-phase req/ack master for the data-cache port
// Holds the stage locked until the handshake has closed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dcache_access_fsm
  import pipe_pkg::*;
(
  input  logic        d_cache_access,
  input  logic        rst,
  input  de_bundle_t  bundle,
  output logic        dc_req,
  output dcache_req_t dc_out,
  input  logic        dc_ack,
  input  logic [31:0] dc_rdata,
  output logic        lock,
  output logic        load_done,
  output logic [31:0] load_data
);

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    RELEASE,
    DONE
  } state_t;

  state_t      state;
  dcache_req_t req_next;
  dcache_req_t req_q;
  logic [31:0] rdata_q;
  logic        cache_op;

  assign cache_op = bundle.ctrl.d_cache_access;

  assign req_next.addr    = bundle.first_input + bundle.offset;
  assign req_next.wdata   = bundle.second_input;
  assign req_next.write   = bundle.ctrl.d_cache_op;
  assign req_next.byte_op = bundle.ctrl.is_byte_op;

  always_ff @(posedge d_cache_access)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else
    begin
      case (state)
        IDLE:    if (cache_op) state <= REQUEST;
        REQUEST: if (dc_ack) state <= RELEASE;
        RELEASE: if (!dc_ack) state <= DONE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge d_cache_access)
  begin
    if (state == IDLE)
      req_q <= req_next;
    if (state == REQUEST && dc_ack)
      rdata_q <= dc_rdata;
  end

  // Request goes out in the first cycle the op sits in the stage
  assign dc_req = (state == IDLE && cache_op) || state == REQUEST;
  assign dc_out = (state == IDLE) ? req_next : req_q;

  assign lock      = (state == IDLE && cache_op) || state == REQUEST || state == RELEASE;
  assign load_done = (state == DONE) && !req_q.write;
  assign load_data = rdata_q;

endmodule

/* hw/decode_execute_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode to execute slice top, instruction in and write-back out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_execute_core
  import core_pkg::*;
  import pipe_pkg::*;
(
  input  logic                  d_cache_access,
  input  logic                  rst,
  input  logic                  instr_valid,
  input  instr_word_t           instr,
  input  logic                  set_nop,
  output logic                  instr_stall,
  output logic                  dc_req,
  output dcache_req_t           dc_out,
  input  logic                  dc_ack,
  input  logic [WORD_WIDTH-1:0] dc_rdata,
  output logic                  wb_valid,
  output wb_result_t            wb
);

  de_bundle_t            decoded_bundle;
  de_bundle_t            stage_bundle;
  logic                  lock;
  logic                  ex_busy;
  logic                  load_done;
  logic [WORD_WIDTH-1:0] load_data;

  assign instr_stall = lock | ex_busy;

  decode_unit decode_unit_inst (
    .instruction    (instr),
    .wb_valid       (wb_valid),
    .wb             (wb),
    .d_cache_access (d_cache_access),
    .rst            (rst),
    .bundle         (decoded_bundle)
  );

  decode_stage_register decode_stage_register_inst (
    .d_cache_access (d_cache_access),
    .rst            (rst),
    .bundle_in      (decoded_bundle),
    .accept         (instr_valid),
    .set_nop        (set_nop),
    .lock           (lock),
    .ex_busy        (ex_busy),
    .bundle_out     (stage_bundle)
  );

  execute_unit execute_unit_inst (
    .d_cache_access (d_cache_access),
    .rst            (rst),
    .bundle         (stage_bundle),
    .load_done      (load_done),
    .load_data      (load_data),
    .ex_busy        (ex_busy),
    .wb_valid       (wb_valid),
    .wb             (wb)
  );

  dcache_access_fsm dcache_access_fsm_inst (
    .d_cache_access (d_cache_access),
    .rst            (rst),
    .bundle         (stage_bundle),
    .dc_req         (dc_req),
    .dc_out         (dc_out),
    .dc_ack         (dc_ack),
    .dc_rdata       (dc_rdata),
    .lock           (lock),
    .load_done      (load_done),
    .load_data      (load_data)
  );

endmodule

/* sim/tb_program_table.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction program for the decode to execute testbench
// Included inside the testbench module after the package imports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_PROGRAM_TABLE_SVH
`define TB_PROGRAM_TABLE_SVH

// Columns: valid, flush, opcode, rd, rs1, low field
// Low field is {rs2, 10'd0} for register ops and the offset otherwise
typedef struct packed {
  logic        valid;
  logic        flush;
  opcode_t     opcode;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [14:0] field;
} program_entry_t;

localparam int PRELOAD_COUNT = 12;
localparam int PROGRAM_LEN   = 28;

localparam program_entry_t PROGRAM_TABLE [PROGRAM_LEN] = '{
  '{1'b1, 1'b0, ADD,  5'd13, 5'd1,  {5'd2, 10'd0}},
  '{1'b1, 1'b0, SUB,  5'd14, 5'd13, {5'd3, 10'd0}},
  '{1'b1, 1'b0, ADDI, 5'd15, 5'd14, 15'h7ffb},
  '{1'b1, 1'b0, ADD,  5'd16, 5'd15, {5'd15, 10'd0}},
  '{1'b1, 1'b0, MUL,  5'd17, 5'd16, {5'd4, 10'd0}},
  '{1'b1, 1'b0, ADD,  5'd18, 5'd17, {5'd1, 10'd0}},
  '{1'b1, 1'b0, MUL,  5'd19, 5'd5,  {5'd6, 10'd0}},
  '{1'b1, 1'b0, MUL,  5'd20, 5'd19, {5'd19, 10'd0}},
  '{1'b1, 1'b0, STW,  5'd18, 5'd0,  15'd16},
  '{1'b1, 1'b0, LDW,  5'd21, 5'd0,  15'd16},
  '{1'b1, 1'b0, LDB,  5'd22, 5'd0,  15'd17},
  '{1'b1, 1'b0, LDB,  5'd23, 5'd0,  15'd19},
  '{1'b1, 1'b0, ADD,  5'd24, 5'd21, {5'd22, 10'd0}},
  // Flushed entries and a bubble leave no trace
  '{1'b1, 1'b1, ADD,  5'd25, 5'd1,  {5'd1, 10'd0}},
  '{1'b0, 1'b0, NOP,  5'd0,  5'd0,  15'd0},
  '{1'b1, 1'b1, STW,  5'd1,  5'd0,  15'd32},
  '{1'b1, 1'b1, LDW,  5'd26, 5'd0,  15'd16},
  '{1'b1, 1'b0, LDW,  5'd26, 5'd0,  15'd32},
  '{1'b1, 1'b0, STW,  5'd20, 5'd7,  15'd100},
  '{1'b1, 1'b0, LDW,  5'd27, 5'd7,  15'd100},
  '{1'b1, 1'b0, STW,  5'd14, 5'd0,  15'h7ff8},
  '{1'b1, 1'b0, LDB,  5'd28, 5'd0,  15'h7ffa},
  '{1'b1, 1'b0, SUB,  5'd29, 5'd28, {5'd27, 10'd0}},
  '{1'b1, 1'b0, MUL,  5'd30, 5'd29, {5'd8, 10'd0}},
  '{1'b1, 1'b1, MUL,  5'd31, 5'd30, {5'd30, 10'd0}},
  '{1'b1, 1'b0, ADDI, 5'd31, 5'd30, 15'd1234},
  '{1'b1, 1'b0, STW,  5'd31, 5'd0,  15'd44},
  '{1'b1, 1'b0, LDW,  5'd25, 5'd0,  15'd44}
};

// Register preload, ADDI from r0 with a random immediate
function automatic program_entry_t preload_entry(input int index);
  program_entry_t entry;
  entry = '{1'b1, 1'b0, ADDI, 5'(index), 5'd0, 15'($urandom)};
  return entry;
endfunction

`endif

/* sim/tb_decode_execute_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the decode to execute slice with a cache model
// Runs the program table against a reference model of registers and memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_decode_execute_core
  import core_pkg::*;
  import pipe_pkg::*;
();

  localparam int SEED           = 72021;
  localparam int ACCEPT_TIMEOUT = 50;
  localparam int DRAIN_TIMEOUT  = 100;

  logic                  d_cache_access = 1'b0;
  logic                  rst;
  logic                  instr_valid;
  instr_word_t           instr;
  logic                  set_nop;
  logic                  instr_stall;
  logic                  dc_req;
  dcache_req_t           dc_out;
  logic                  dc_ack = 1'b0;
  logic [WORD_WIDTH-1:0] dc_rdata = '0;
  logic                  wb_valid;
  wb_result_t            wb;

  logic [31:0] model_regs [32];
  logic [31:0] model_mem [256];
  logic [31:0] cache_mem [256];
  wb_result_t  exp_wb [$];
  dcache_req_t exp_req [$];

  `include "tb_program_table.svh"

  decode_execute_core decode_execute_core_inst (
    .d_cache_access (d_cache_access),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .set_nop        (set_nop),
    .instr_stall    (instr_stall),
    .dc_req         (dc_req),
    .dc_out         (dc_out),
    .dc_ack         (dc_ack),
    .dc_rdata       (dc_rdata),
    .wb_valid       (wb_valid),
    .wb             (wb)
  );

  always #20 d_cache_access = ~d_cache_access;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_wb(input wb_result_t expected, input wb_result_t actual);
    if (actual !== expected)
      abort_run($sformatf("Fail %0t ns: write-back r%0d = %h, expected r%0d = %h",
                          $time, actual.rd, actual.value, expected.rd, expected.value));
  endtask

  task automatic check_store(input dcache_req_t expected, input dcache_req_t actual);
    if (actual !== expected)
      abort_run($sformatf("Fail %0t ns: store addr %h data %h write %b, expected %h %h %b",
                          $time, actual.addr, actual.wdata, actual.write,
                          expected.addr, expected.wdata, expected.write));
  endtask

  // Write data of a load request carries no meaning
  task automatic check_load_request(input dcache_req_t expected, input dcache_req_t actual);
    if (actual.addr !== expected.addr || actual.write !== expected.write ||
        actual.byte_op !== expected.byte_op)
      abort_run($sformatf("Fail %0t ns: load addr %h byte %b, expected addr %h byte %b",
                          $time, actual.addr, actual.byte_op, expected.addr, expected.byte_op));
  endtask

  function automatic instr_word_t encode(input program_entry_t entry);
    instr_word_t word;
    word.m_fmt.opcode = entry.opcode;
    word.m_fmt.rd     = entry.rd;
    word.m_fmt.rs1    = entry.rs1;
    word.m_fmt.offset = entry.field;
    return word;
  endfunction

  task automatic record_write_back(input logic [4:0] rd, input logic [31:0] value);
    wb_result_t result;
    result.rd    = rd;
    result.value = value;
    exp_wb.push_back(result);
    if (rd != 5'd0)
      model_regs[rd] = value;
  endtask

  // Architectural effect of one accepted instruction
  task automatic model_accept(input instr_word_t word);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] mem_word;
    dcache_req_t req;
    a        = model_regs[word.r_fmt.rs1];
    b        = model_regs[word.r_fmt.rs2];
    imm      = {{17{word.m_fmt.offset[14]}}, word.m_fmt.offset};
    addr     = a + imm;
    mem_word = model_mem[addr[9:2]];
    req      = '{addr: addr, wdata: '0, write: 1'b0, byte_op: 1'b0};
    case (word.m_fmt.opcode)
      ADD:  record_write_back(word.m_fmt.rd, a + b);
      SUB:  record_write_back(word.m_fmt.rd, a - b);
      MUL:  record_write_back(word.m_fmt.rd, a * b);
      ADDI: record_write_back(word.m_fmt.rd, addr);
      LDW:
      begin
        exp_req.push_back(req);
        record_write_back(word.m_fmt.rd, mem_word);
      end
      LDB:
      begin
        req.byte_op = 1'b1;
        exp_req.push_back(req);
        record_write_back(word.m_fmt.rd, (mem_word >> (8 * addr[1:0])) & 32'h0000_00ff);
      end
      STW:
      begin
        req.write  = 1'b1;
        req.wdata  = model_regs[word.m_fmt.rd];
        exp_req.push_back(req);
        model_mem[addr[9:2]] = req.wdata;
      end
      default:
      begin
      end
    endcase
  endtask

  // Drives one entry and holds it until the core takes it
  task automatic apply_entry(input program_entry_t entry);
    int waited;
    waited = 0;
    instr_valid <= entry.valid;
    set_nop     <= entry.flush;
    instr       <= encode(entry);
    @(posedge d_cache_access);
    while (instr_stall)
    begin
      waited++;
      if (waited > ACCEPT_TIMEOUT)
        abort_run("Timed out waiting for the core to accept an instruction");
      @(posedge d_cache_access);
    end
    if (entry.valid && !entry.flush)
      model_accept(encode(entry));
  endtask

  // Cache model with random ack and release delays
  int cache_wait = -1;

  always @(posedge d_cache_access)
  begin
    if (rst)
    begin
      dc_ack     <= 1'b0;
      cache_wait = -1;
      foreach (cache_mem[i])
        cache_mem[i] = model_mem[i];
    end
    else if (!dc_ack)
    begin
      if (dc_req)
      begin
        if (cache_wait < 0)
          cache_wait = $urandom_range(5, 0);
        if (cache_wait == 0)
        begin
          if (dc_out.write)
            cache_mem[dc_out.addr[9:2]] = dc_out.wdata;
          else
            dc_rdata <= cache_mem[dc_out.addr[9:2]];
          dc_ack     <= 1'b1;
          cache_wait = -1;
        end
        else
          cache_wait--;
      end
    end
    else if (!dc_req)
    begin
      if (cache_wait < 0)
        cache_wait = $urandom_range(5, 0);
      if (cache_wait == 0)
      begin
        dc_ack     <= 1'b0;
        dc_rdata   <= $urandom;
        cache_wait = -1;
      end
      else
        cache_wait--;
    end
  end

  // Output monitor, handshake order and result checks
  logic        reset_seen = 1'b0;
  logic        prev_req;
  logic        prev_ack;
  dcache_req_t prev_out;

  always @(posedge d_cache_access)
  begin
    dcache_req_t req_exp;
    if (rst)
    begin
      if (reset_seen && (dc_req || wb_valid || instr_stall))
        abort_run($sformatf("Fail %0t ns: outputs active during reset", $time));
      reset_seen = 1'b1;
      prev_req   = 1'b0;
      prev_ack   = 1'b0;
    end
    else
    begin
      if (dc_req && !prev_req)
      begin
        if (dc_ack)
          abort_run($sformatf("Fail %0t ns: dc_req raised while dc_ack high", $time));
        if (exp_req.size() == 0)
          abort_run($sformatf("Fail %0t ns: cache request with none expected", $time));
        req_exp = exp_req.pop_front();
        if (req_exp.write)
          check_store(req_exp, dc_out);
        else
          check_load_request(req_exp, dc_out);
      end
      if (dc_req && prev_req && dc_out !== prev_out)
        abort_run($sformatf("Fail %0t ns: request changed while dc_req high", $time));
      if (!dc_req && prev_req && !prev_ack)
        abort_run($sformatf("Fail %0t ns: dc_req dropped before dc_ack", $time));
      if (wb_valid)
      begin
        if (exp_wb.size() == 0)
          abort_run($sformatf("Fail %0t ns: write-back r%0d with none expected", $time, wb.rd));
        check_wb(exp_wb.pop_front(), wb);
      end
      prev_req = dc_req;
      prev_ack = dc_ack;
      prev_out = dc_out;
    end
  end

  initial
  begin
    int waited;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = NOP_INSTRUCTION;
    set_nop     = 1'b0;
    void'($urandom(SEED));
    foreach (model_mem[i])
      model_mem[i] = $urandom;
    foreach (model_regs[i])
      model_regs[i] = '0;

    repeat (3) @(posedge d_cache_access);
    rst <= 1'b0;

    for (int r = 1; r <= PRELOAD_COUNT; r++)
      apply_entry(preload_entry(r));
    for (int i = 0; i < PROGRAM_LEN; i++)
      apply_entry(PROGRAM_TABLE[i]);
    instr_valid <= 1'b0;
    set_nop     <= 1'b0;

    waited = 0;
    while (exp_wb.size() != 0 || exp_req.size() != 0 || instr_stall)
    begin
      waited++;
      if (waited > DRAIN_TIMEOUT)
        abort_run("Timed out waiting for the last results to come out");
      @(posedge d_cache_access);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

/* decode_execute_core.f */
+incdir+sim
hw/core_pkg.sv
hw/pipe_pkg.sv
hw/register_file.sv
hw/decode_unit.sv
hw/decode_stage_register.sv
hw/mul_latency_timer.sv
hw/execute_unit.sv
hw/dcache_access_fsm.sv
hw/decode_execute_core.sv
sim/tb_decode_execute_core.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the decode to execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module tb_decode_execute_core \
  -f decode_execute_core.f \
  -o tb_decode_execute_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_decode_execute_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished with status 0"
exit 0
